/* build.f */
+incdir+verilog
verilog/mipsIsaPkg.sv
verilog/mipsCtrlPkg.sv
verilog/mainDecoder.sv
verilog/aluDecoder.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/nextPcUnit.sv
verilog/singleCycleMips.sv
verification/singleCycleMipsTb.sv

/* Bender.yml */
package:
  name: singleCycleMips

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mipsIsaPkg.sv
      - verilog/mipsCtrlPkg.sv
      - verilog/mainDecoder.sv
      - verilog/aluDecoder.sv
      - verilog/alu.sv
      - verilog/registerFile.sv
      - verilog/nextPcUnit.sv
      - verilog/singleCycleMips.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/singleCycleMipsTb.sv

/* verification/singleCycleMipsTb.sv */
`timescale 1ns/100ps
`include "mipsSettings.svh"

module singleCycleMipsTb;

    localparam int resetCycles = 16;
    localparam int numTests    = 6;
    // Longest program run, R-type test plus one
    localparam int longestRun  = 17;
    // Twice the worst case of every test
    localparam int cycleLimit  = 2 * numTests * (resetCycles + longestRun);
    localparam int imemWords   = 256;
    localparam int dmemWords   = 2 ** `MIPS_MEM_AW;

    logic                   clk;
    logic                   rst_n;
    mipsIsaPkg::dataWord    instr;
    mipsIsaPkg::dataWord    instrAddr;
    mipsIsaPkg::dataWord    memReadData;
    mipsCtrlPkg::memRequest mem;

    mipsIsaPkg::dataWord imem [imemWords];
    mipsIsaPkg::dataWord dmem [dmemWords];
    integer              seed;
    int                  cycleCount = 0;

    singleCycleMips UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .instrAddr  (instrAddr),
        .memReadData(memReadData),
        .mem        (mem)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fetch by word index of the byte address
    assign instr = imem[instrAddr[9:2]];
    // Same-cycle read data
    assign memReadData = dmem[mem.addr];

    // Store lands at the rising edge
    always @(posedge clk) begin
        if (!mem.cen && !mem.wen) begin
            if (rst_n) begin
                reportFailure("A store reached data memory while reset was held");
            end else begin
                dmem[mem.addr] <= mem.writeData;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            reportFailure($sformatf("Timeout after %0d cycles, the tests did not finish",
                                    cycleLimit));
        end
    end

    task automatic reportFailure(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkWord(input mipsIsaPkg::dataWord expected,
                             input mipsIsaPkg::dataWord actual, input string what);
        if (actual !== expected) begin
            reportFailure($sformatf("Mismatch at %0d ns: %s, expected %h, got %h",
                                    $time, what, expected, actual));
        end
    endtask

    // Strobes only, address and data checked as words
    task automatic checkRequest(input mipsCtrlPkg::memRequest expected,
                                input mipsCtrlPkg::memRequest actual, input string what);
        logic [2:0] want;
        logic [2:0] got;
        want = {expected.cen, expected.wen, expected.oen};
        got  = {actual.cen, actual.wen, actual.oen};
        if (got !== want) begin
            reportFailure($sformatf("Mismatch at %0d ns: %s, expected cen wen oen %b, got %b",
                                    $time, what, want, got));
        end
    endtask

    function automatic mipsCtrlPkg::memRequest requestWith(input logic cen, input logic wen,
                                                           input logic oen);
        mipsCtrlPkg::memRequest r;
        r     = '0;
        r.cen = cen;
        r.wen = wen;
        r.oen = oen;
        return r;
    endfunction

    function automatic mipsIsaPkg::dataWord rWord(input mipsIsaPkg::funct f,
                                                  input mipsIsaPkg::regIndex rs,
                                                  input mipsIsaPkg::regIndex rt,
                                                  input mipsIsaPkg::regIndex rd,
                                                  input logic [4:0] shamt);
        mipsIsaPkg::instrFields w;
        w                          = '0;
        w.op                       = mipsIsaPkg::rFormat;
        w.body.regs.rs             = rs;
        w.body.regs.rt             = rt;
        w.body.regs.low.r.rd       = rd;
        w.body.regs.low.r.shamt    = shamt;
        w.body.regs.low.r.functCode = f;
        return w;
    endfunction

    function automatic mipsIsaPkg::dataWord immWord(input mipsIsaPkg::opcode op,
                                                    input mipsIsaPkg::regIndex rs,
                                                    input mipsIsaPkg::regIndex rt,
                                                    input logic [15:0] imm);
        mipsIsaPkg::instrFields w;
        w                  = '0;
        w.op               = op;
        w.body.regs.rs     = rs;
        w.body.regs.rt     = rt;
        w.body.regs.low.imm = imm;
        return w;
    endfunction

    function automatic mipsIsaPkg::dataWord jumpWord(input mipsIsaPkg::opcode op,
                                                     input logic [25:0] target);
        mipsIsaPkg::instrFields w;
        w             = '0;
        w.op          = op;
        w.body.target = target;
        return w;
    endfunction

    function automatic mipsIsaPkg::dataWord signExtend(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // pc+4 plus the word offset
    function automatic mipsIsaPkg::dataWord branchTarget(input mipsIsaPkg::dataWord pc,
                                                         input logic [15:0] imm);
        return pc + 4 + (signExtend(imm) << 2);
    endfunction

    function automatic mipsIsaPkg::dataWord jumpTarget(input mipsIsaPkg::dataWord pc,
                                                       input logic [25:0] target);
        return {pc[31:28], target, 2'b00};
    endfunction

    // Every word distinct, so a stray write shows up
    function automatic mipsIsaPkg::dataWord fillWord(input logic [`MIPS_MEM_AW-1:0] a);
        return 32'hBAD0_0000 | mipsIsaPkg::dataWord'(a);
    endfunction

    function automatic logic [15:0] randomImm();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // Assert reset, then load fresh memories
    task automatic holdReset;
        @(posedge clk);
        #1 rst_n = 1'b1;
        for (int a = 0; a < imemWords; a++) begin
            imem[a] = '0;
        end
        for (int a = 0; a < dmemWords; a++) begin
            dmem[a] = fillWord(a[`MIPS_MEM_AW-1:0]);
        end
    endtask

    // Returns mid-cycle with the first instruction presented
    task automatic releaseReset;
        mipsIsaPkg::instrFields first;
        mipsCtrlPkg::memRequest idle;
        first = imem[0];
        // cen and wen forced, oen still follows the decode
        idle  = requestWith(1'b1, 1'b1, (first.op == mipsIsaPkg::lw) ? 1'b0 : 1'b1);
        repeat (resetCycles - 1) begin
            @(posedge clk);
            @(negedge clk);
            checkWord(`MIPS_RESET_PC, instrAddr, "instrAddr during reset");
            checkRequest(idle, mem, "strobes during reset");
        end
        @(posedge clk);
        #1 rst_n = 1'b0;
        @(negedge clk);
        checkWord(`MIPS_RESET_PC, instrAddr, "instrAddr right after reset");
    endtask

    // One instruction per step
    task automatic runCycles(input int n);
        repeat (n) begin
            @(negedge clk);
        end
    endtask

    task automatic resetBehavior;
        holdReset();
        imem[0] = immWord(mipsIsaPkg::sw, 5'd0, 5'd0, 16'h0010);
        releaseReset();
        checkRequest(requestWith(1'b0, 1'b0, 1'b1), mem, "store strobes after reset");
        checkWord(32'd4, mipsIsaPkg::dataWord'(mem.addr), "store word address");
        checkWord(fillWord(7'd4), dmem[4], "word 4 before first store");
        runCycles(1);
        checkWord(32'd0, dmem[4], "stored $0");
        checkWord(32'd4, instrAddr, "fetch after first instruction");
    endtask

    task automatic addiStores;
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immZ;
        immA = randomImm();
        immB = randomImm();
        immZ = randomImm();
        holdReset();
        imem[0] = immWord(mipsIsaPkg::addi, 5'd0, 5'd1, immA);
        imem[1] = immWord(mipsIsaPkg::sw, 5'd0, 5'd1, 16'h0000);
        imem[2] = immWord(mipsIsaPkg::addi, 5'd1, 5'd2, immB);
        imem[3] = immWord(mipsIsaPkg::sw, 5'd0, 5'd2, 16'h0004);
        // $0 keeps zero
        imem[4] = immWord(mipsIsaPkg::addi, 5'd0, 5'd0, immZ);
        imem[5] = immWord(mipsIsaPkg::sw, 5'd0, 5'd0, 16'h0008);
        releaseReset();
        runCycles(6);
        checkWord(signExtend(immA), dmem[0], "addi from $0");
        checkWord(signExtend(immA) + signExtend(immB), dmem[1], "addi chained sum");
        checkWord(32'd0, dmem[2], "addi into $0");
    endtask

    task automatic rTypeOps;
        logic [15:0]         immA;
        logic [15:0]         immB;
        logic [15:0]         rnd;
        logic [4:0]          sh;
        mipsIsaPkg::dataWord a;
        mipsIsaPkg::dataWord b;
        mipsIsaPkg::dataWord expected [7];
        // Negative a against positive b, signed and unsigned order differ
        immA = randomImm() | 16'h8000;
        immB = randomImm() & 16'h7fff;
        rnd  = randomImm();
        sh   = rnd[4:0];
        a    = signExtend(immA);
        b    = signExtend(immB);
        expected[0] = a + b;
        expected[1] = a - b;
        expected[2] = a & b;
        expected[3] = a | b;
        // Negative a is always below non-negative b
        expected[4] = 32'd1;
        expected[5] = a << sh;
        expected[6] = a >> sh;
        holdReset();
        imem[0]  = immWord(mipsIsaPkg::addi, 5'd0, 5'd1, immA);
        imem[1]  = immWord(mipsIsaPkg::addi, 5'd0, 5'd2, immB);
        imem[2]  = rWord(mipsIsaPkg::add, 5'd1, 5'd2, 5'd3, 5'd0);
        imem[4]  = rWord(mipsIsaPkg::sub, 5'd1, 5'd2, 5'd4, 5'd0);
        imem[6]  = rWord(mipsIsaPkg::andOp, 5'd1, 5'd2, 5'd5, 5'd0);
        imem[8]  = rWord(mipsIsaPkg::orOp, 5'd1, 5'd2, 5'd6, 5'd0);
        imem[10] = rWord(mipsIsaPkg::slt, 5'd1, 5'd2, 5'd7, 5'd0);
        // Shift source sits in rt
        imem[12] = rWord(mipsIsaPkg::sll, 5'd0, 5'd1, 5'd8, sh);
        imem[14] = rWord(mipsIsaPkg::srl, 5'd0, 5'd1, 5'd9, sh);
        for (int k = 0; k < 7; k++) begin
            imem[3 + 2 * k] = immWord(mipsIsaPkg::sw, 5'd0, 5'(3 + k), 16'(4 * k));
        end
        releaseReset();
        runCycles(16);
        for (int k = 0; k < 7; k++) begin
            checkWord(expected[k], dmem[k], $sformatf("R-type result %0d", k));
        end
    endtask

    task automatic loadStoreRoundTrip;
        logic [15:0]         value;
        mipsIsaPkg::dataWord sum;
        mipsIsaPkg::dataWord wordAddr;
        value    = randomImm();
        // Base plus offset wraps past bit 8
        sum      = signExtend(16'h01f0) + signExtend(16'h0020);
        wordAddr = {25'b0, sum[8:2]};
        holdReset();
        imem[0] = immWord(mipsIsaPkg::addi, 5'd0, 5'd1, 16'h01f0);
        imem[1] = immWord(mipsIsaPkg::addi, 5'd0, 5'd2, value);
        imem[2] = immWord(mipsIsaPkg::sw, 5'd1, 5'd2, 16'h0020);
        imem[3] = immWord(mipsIsaPkg::lw, 5'd1, 5'd3, 16'h0020);
        imem[4] = immWord(mipsIsaPkg::sw, 5'd0, 5'd3, 16'h0020);
        releaseReset();
        runCycles(2);
        checkRequest(requestWith(1'b0, 1'b0, 1'b1), mem, "sw strobes");
        checkWord(wordAddr, mipsIsaPkg::dataWord'(mem.addr), "sw word address");
        runCycles(1);
        checkRequest(requestWith(1'b0, 1'b1, 1'b0), mem, "lw strobes");
        checkWord(wordAddr, mipsIsaPkg::dataWord'(mem.addr), "lw word address");
        runCycles(1);
        checkWord(32'd8, mipsIsaPkg::dataWord'(mem.addr), "second sw word address");
        runCycles(1);
        checkWord(signExtend(value), dmem[wordAddr[6:0]], "first stored word");
        checkWord(signExtend(value), dmem[8], "round-tripped word");
    endtask

    task automatic branchFlow;
        mipsIsaPkg::dataWord expected [$];
        holdReset();
        imem[0]  = immWord(mipsIsaPkg::addi, 5'd0, 5'd1, 16'd5);
        imem[1]  = immWord(mipsIsaPkg::addi, 5'd0, 5'd2, 16'd5);
        imem[2]  = immWord(mipsIsaPkg::beq, 5'd1, 5'd2, 16'd2);
        imem[5]  = immWord(mipsIsaPkg::bne, 5'd1, 5'd2, 16'd3);
        imem[6]  = immWord(mipsIsaPkg::beq, 5'd1, 5'd0, 16'd3);
        imem[7]  = immWord(mipsIsaPkg::bne, 5'd1, 5'd0, 16'd1);
        imem[9]  = immWord(mipsIsaPkg::beq, 5'd1, 5'd2, 16'd2);
        // Backward by two words
        imem[12] = immWord(mipsIsaPkg::beq, 5'd0, 5'd0, 16'hfffe);
        expected.push_back(32'd0);
        expected.push_back(32'd4);
        expected.push_back(32'd8);
        expected.push_back(branchTarget(32'd8, 16'd2));
        expected.push_back(32'd20 + 4);
        expected.push_back(32'd24 + 4);
        expected.push_back(branchTarget(32'd28, 16'd1));
        expected.push_back(branchTarget(32'd36, 16'd2));
        expected.push_back(branchTarget(32'd48, 16'hfffe));
        expected.push_back(32'd44 + 4);
        releaseReset();
        foreach (expected[k]) begin
            checkWord(expected[k], instrAddr, $sformatf("branch fetch %0d", k));
            runCycles(1);
        end
    endtask

    task automatic jumpFlow;
        mipsIsaPkg::dataWord expected [$];
        holdReset();
        imem[0] = jumpWord(mipsIsaPkg::j, 26'd4);
        imem[4] = jumpWord(mipsIsaPkg::jal, 26'd8);
        imem[8] = immWord(mipsIsaPkg::sw, 5'd0, 5'd31, 16'h0000);
        imem[9] = rWord(mipsIsaPkg::jr, 5'd31, 5'd0, 5'd0, 5'd0);
        expected.push_back(32'd0);
        expected.push_back(jumpTarget(32'd0, 26'd4));
        expected.push_back(jumpTarget(32'd16, 26'd8));
        expected.push_back(32'd36);
        // Link is the jal address plus 4
        expected.push_back(32'd16 + 4);
        expected.push_back(32'd24);
        releaseReset();
        foreach (expected[k]) begin
            checkWord(expected[k], instrAddr, $sformatf("jump fetch %0d", k));
            runCycles(1);
        end
        checkWord(32'd16 + 4, dmem[0], "stored $31");
    endtask

    initial begin
        seed  = 32'h27d7_2920;
        rst_n = 1'b1;
        for (int a = 0; a < imemWords; a++) begin
            imem[a] = '0;
        end
        for (int a = 0; a < dmemWords; a++) begin
            dmem[a] = fillWord(a[`MIPS_MEM_AW-1:0]);
        end
        resetBehavior();
        addiStores();
        rTypeOps();
        loadStoreRoundTrip();
        branchFlow();
        jumpFlow();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verilog/singleCycleMips.sv */
`timescale 1ns/100ps
`include "mipsSettings.svh"

module singleCycleMips (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mipsIsaPkg::dataWord    instr,
    output mipsIsaPkg::dataWord    instrAddr,
    input  mipsIsaPkg::dataWord    memReadData,
    output mipsCtrlPkg::memRequest mem
);

    mipsIsaPkg::instrFields  fields;
    mipsCtrlPkg::ctrlSignals ctrl;
    mipsCtrlPkg::aluCtrl     ctrlCode;
    logic [2:0]              memStrobes;
    mipsIsaPkg::regIndex     readA;
    mipsIsaPkg::regIndex     writeSel;
    mipsIsaPkg::dataWord     writeData;
    mipsIsaPkg::dataWord     rsData;
    mipsIsaPkg::dataWord     rtData;
    mipsIsaPkg::dataWord     result;
    mipsIsaPkg::dataWord     pcPlus4;
    logic                    branchTaken;

    // Raw word straight into the field view
    assign fields = instr;

    mainDecoder uMainDecoder (
        .fields    (fields),
        .ctrl      (ctrl),
        .memStrobes(memStrobes)
    );

    aluDecoder uAluDecoder (
        .op       (ctrl.aluOp),
        .functCode(fields.body.regs.low.r.functCode),
        .ctrlCode (ctrlCode)
    );

    // Shifts take their value from rt
    assign readA = (ctrl.opSel == mipsCtrlPkg::shamtExt) ? fields.body.regs.rt
                                                         : fields.body.regs.rs;

    // jal links into $31
    assign writeSel = ctrl.linkRa ? mipsIsaPkg::regIndex'(`MIPS_RA_REG) :
                      ctrl.regDst ? fields.body.regs.low.r.rd : fields.body.regs.rt;

    assign writeData = ctrl.memToReg ? memReadData :
                       ctrl.linkRa   ? pcPlus4     : result;

    registerFile uRegisterFile (
        .clk      (clk),
        .rst_n    (rst_n),
        .readA    (readA),
        .readB    (fields.body.regs.rt),
        .writeSel (writeSel),
        .writeEn  (ctrl.regWrite),
        .writeData(writeData),
        .dataA    (rsData),
        .dataB    (rtData)
    );

    alu uAlu (
        .srcA       (rsData),
        .rtData     (rtData),
        .fields     (fields),
        .opSel      (ctrl.opSel),
        .ctrlCode   (ctrlCode),
        .result     (result),
        .branchTaken(branchTaken)
    );

    nextPcUnit uNextPcUnit (
        .clk        (clk),
        .rst_n      (rst_n),
        .fields     (fields),
        .ctrl       (ctrl),
        .branchTaken(branchTaken),
        .jumpReg    (rsData),
        .pc         (instrAddr),
        .pcPlus4    (pcPlus4)
    );

    // No access while reset is held
    assign mem.cen       = rst_n | memStrobes[2];
    assign mem.wen       = rst_n | memStrobes[1];
    assign mem.oen       = memStrobes[0];
    // Word address from the byte address
    assign mem.addr      = result[`MIPS_MEM_AW+1:2];
    assign mem.writeData = rtData;

endmodule

/* verilog/nextPcUnit.sv */
`timescale 1ns/100ps
`include "mipsSettings.svh"

module nextPcUnit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mipsIsaPkg::instrFields  fields,
    input  mipsCtrlPkg::ctrlSignals ctrl,
    input  logic                    branchTaken,
    input  mipsIsaPkg::dataWord     jumpReg,
    output mipsIsaPkg::dataWord     pc,
    output mipsIsaPkg::dataWord     pcPlus4
);

    mipsIsaPkg::dataWord branchOffset;
    mipsIsaPkg::dataWord nextPc;

    assign pcPlus4 = pc + 4;

    // Sign-extended word offset
    assign branchOffset = {{(`MIPS_XLEN-18){fields.body.regs.low.imm[15]}},
                           fields.body.regs.low.imm, 2'b00};

    always_comb begin
        if (ctrl.jump) begin
            // Stay in the current 256 MB region
            nextPc = {pc[`MIPS_XLEN-1:`MIPS_XLEN-4], fields.body.target, 2'b00};
        end else if (ctrl.jumpReg) begin
            nextPc = jumpReg;
        end else if (ctrl.branch && branchTaken) begin
            nextPc = pcPlus4 + branchOffset;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // jr into a misaligned register value shows up here
    pcAligned: assert property (@(posedge clk) disable iff (rst_n) pc[1:0] == 2'b00);

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/100ps
`include "mipsSettings.svh"

module registerFile (
    input  logic                clk,
    input  logic                rst_n,
    input  mipsIsaPkg::regIndex readA,
    input  mipsIsaPkg::regIndex readB,
    input  mipsIsaPkg::regIndex writeSel,
    input  logic                writeEn,
    input  mipsIsaPkg::dataWord writeData,
    output mipsIsaPkg::dataWord dataA,
    output mipsIsaPkg::dataWord dataB
);

    mipsIsaPkg::dataWord regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeSel != '0)) begin
            // $0 stays zero
            regs[writeSel] <= writeData;
        end
    end

    // Combinational reads, $0 hardwired
    assign dataA = (readA == '0) ? '0 : regs[readA];
    assign dataB = (readB == '0) ? '0 : regs[readB];

    // Write-back mux must settle to a known word
    writeDataKnown: assert property (@(posedge clk) disable iff (rst_n)
        writeEn |-> !$isunknown(writeData));

endmodule

/* verilog/alu.sv */
`timescale 1ns/100ps
`include "mipsSettings.svh"

module alu (
    input  mipsIsaPkg::dataWord    srcA,
    input  mipsIsaPkg::dataWord    rtData,
    input  mipsIsaPkg::instrFields fields,
    input  mipsCtrlPkg::operandSel opSel,
    input  mipsCtrlPkg::aluCtrl    ctrlCode,
    output mipsIsaPkg::dataWord    result,
    output logic                   branchTaken
);

    mipsIsaPkg::dataWord srcB;

    // Second operand
    always_comb begin
        case (opSel)
            mipsCtrlPkg::immExt:
                srcB = {{(`MIPS_XLEN-16){fields.body.regs.low.imm[15]}},
                        fields.body.regs.low.imm};
            mipsCtrlPkg::shamtExt:
                srcB = {{(`MIPS_XLEN-5){1'b0}}, fields.body.regs.low.r.shamt};
            default:
                srcB = rtData;
        endcase
    end

    always_comb begin
        case (ctrlCode)
            mipsCtrlPkg::andOp: result = srcA & srcB;
            mipsCtrlPkg::orOp:  result = srcA | srcB;
            mipsCtrlPkg::add:   result = srcA + srcB;
            mipsCtrlPkg::sub,
            mipsCtrlPkg::subNe: result = srcA - srcB;
            // Signed compare
            mipsCtrlPkg::slt:
                result = {{(`MIPS_XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            // Shift amount from shamt, value from rt
            mipsCtrlPkg::sll:   result = srcA << srcB[4:0];
            mipsCtrlPkg::srl:   result = srcA >> srcB[4:0];
            default:            result = '0;
        endcase
    end

    // beq on equal, bne on different
    assign branchTaken = ((ctrlCode == mipsCtrlPkg::sub) && (srcA == srcB)) ||
                         ((ctrlCode == mipsCtrlPkg::subNe) && (srcA != srcB));

    // Decoder never selects the spare encoding
    operandDefined: assert property (@(opSel)
        !$isunknown(opSel) |->
            opSel inside {mipsCtrlPkg::regRt, mipsCtrlPkg::immExt, mipsCtrlPkg::shamtExt});

endmodule

/* verilog/aluDecoder.sv */
`timescale 1ns/100ps
`include "mipsSettings.svh"

module aluDecoder (
    input  mipsCtrlPkg::aluOp   op,
    input  mipsIsaPkg::funct    functCode,
    output mipsCtrlPkg::aluCtrl ctrlCode
);

    always_comb begin
        case (op)
            // Address and immediate arithmetic
            mipsCtrlPkg::addClass: ctrlCode = mipsCtrlPkg::add;
            mipsCtrlPkg::branchEq: ctrlCode = mipsCtrlPkg::sub;
            mipsCtrlPkg::branchNe: ctrlCode = mipsCtrlPkg::subNe;
            mipsCtrlPkg::rType: begin
                case (functCode)
                    mipsIsaPkg::add:   ctrlCode = mipsCtrlPkg::add;
                    mipsIsaPkg::sub:   ctrlCode = mipsCtrlPkg::sub;
                    mipsIsaPkg::andOp: ctrlCode = mipsCtrlPkg::andOp;
                    mipsIsaPkg::orOp:  ctrlCode = mipsCtrlPkg::orOp;
                    mipsIsaPkg::slt:   ctrlCode = mipsCtrlPkg::slt;
                    mipsIsaPkg::sll:   ctrlCode = mipsCtrlPkg::sll;
                    mipsIsaPkg::srl:   ctrlCode = mipsCtrlPkg::srl;
                    // jr and unlisted codes, result unused
                    default:           ctrlCode = mipsCtrlPkg::add;
                endcase
            end
            default: ctrlCode = mipsCtrlPkg::add;
        endcase
    end

endmodule

/* verilog/mainDecoder.sv */
`timescale 1ns/100ps
`include "mipsSettings.svh"

module mainDecoder (
    input  mipsIsaPkg::instrFields  fields,
    output mipsCtrlPkg::ctrlSignals ctrl,
    output logic [2:0]              memStrobes
);

    always_comb begin
        // Everything off, so unknown opcodes only advance the PC
        ctrl       = '0;
        ctrl.opSel = mipsCtrlPkg::regRt;
        ctrl.aluOp = mipsCtrlPkg::addClass;
        case (fields.op)
            mipsIsaPkg::rFormat: begin
                ctrl.regDst = 1'b1;
                ctrl.aluOp  = mipsCtrlPkg::rType;
                case (fields.body.regs.low.r.functCode)
                    mipsIsaPkg::sll, mipsIsaPkg::srl: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.opSel    = mipsCtrlPkg::shamtExt;
                    end
                    mipsIsaPkg::add, mipsIsaPkg::sub, mipsIsaPkg::andOp,
                    mipsIsaPkg::orOp, mipsIsaPkg::slt: begin
                        ctrl.regWrite = 1'b1;
                    end
                    mipsIsaPkg::jr: begin
                        ctrl.jumpReg = 1'b1;
                    end
                    default: begin
                        // Unlisted funct, no write
                        ctrl.regWrite = 1'b0;
                    end
                endcase
            end
            mipsIsaPkg::addi: begin
                ctrl.regWrite = 1'b1;
                ctrl.opSel    = mipsCtrlPkg::immExt;
            end
            mipsIsaPkg::lw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.opSel    = mipsCtrlPkg::immExt;
            end
            mipsIsaPkg::sw: begin
                ctrl.memWrite = 1'b1;
                ctrl.opSel    = mipsCtrlPkg::immExt;
            end
            mipsIsaPkg::beq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = mipsCtrlPkg::branchEq;
            end
            mipsIsaPkg::bne: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = mipsCtrlPkg::branchNe;
            end
            mipsIsaPkg::j: begin
                ctrl.jump = 1'b1;
            end
            mipsIsaPkg::jal: begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.linkRa   = 1'b1;
            end
            default: begin
                ctrl.jump = 1'b0;
            end
        endcase
    end

    // Order is {cen, wen, oen}, all low active
    assign memStrobes = {~(ctrl.memRead | ctrl.memWrite), ~ctrl.memWrite, ~ctrl.memRead};

    // Idle, load or store only, never read and write together
    strobePattern: assert property (@(fields)
        memStrobes inside {3'b111, 3'b010, 3'b001});

endmodule

/* verilog/mipsCtrlPkg.sv */
`include "mipsSettings.svh"

package mipsCtrlPkg;

    // Operation class handed from main decoder to ALU decoder
    typedef enum logic [1:0] {
        addClass = 2'b00,
        branchEq = 2'b01,
        rType    = 2'b10,
        branchNe = 2'b11
    } aluOp;

    // ALU function codes
    typedef enum logic [3:0] {
        andOp = 4'b0000,
        orOp  = 4'b0001,
        add   = 4'b0010,
        sub   = 4'b0110,
        slt   = 4'b0111,
        srl   = 4'b1101,
        subNe = 4'b1110,
        sll   = 4'b1111
    } aluCtrl;

    // Second ALU operand source, 2'b10 unused
    typedef enum logic [1:0] {
        regRt    = 2'b00,
        immExt   = 2'b01,
        shamtExt = 2'b11
    } operandSel;

    typedef struct packed {
        logic      regDst;
        logic      regWrite;
        logic      memToReg;
        logic      memWrite;
        logic      memRead;
        logic      branch;
        logic      jump;
        logic      jumpReg;
        logic      linkRa;
        operandSel opSel;
        aluOp      aluOp;
    } ctrlSignals;

    // Outgoing data memory port, strobes low active
    typedef struct packed {
        logic                   cen;
        logic                   wen;
        logic                   oen;
        logic [`MIPS_MEM_AW-1:0] addr;
        logic [`MIPS_XLEN-1:0]   writeData;
    } memRequest;

endpackage

/* verilog/mipsIsaPkg.sv */
`include "mipsSettings.svh"

package mipsIsaPkg;

    typedef logic [`MIPS_XLEN-1:0] dataWord;
    typedef logic [$clog2(`MIPS_NUM_REGS)-1:0] regIndex;

    // Primary opcode, bits 31 to 26
    typedef enum logic [5:0] {
        rFormat = 6'h00,
        j       = 6'h02,
        jal     = 6'h03,
        beq     = 6'h04,
        bne     = 6'h05,
        addi    = 6'h08,
        lw      = 6'h23,
        sw      = 6'h2b
    } opcode;

    // R-type function codes
    typedef enum logic [5:0] {
        sll   = 6'h00,
        srl   = 6'h02,
        jr    = 6'h08,
        add   = 6'h20,
        sub   = 6'h22,
        andOp = 6'h24,
        orOp  = 6'h25,
        slt   = 6'h2a
    } funct;

    // Low half of an R-type word
    typedef struct packed {
        regIndex    rd;
        logic [4:0] shamt;
        funct       functCode;
    } rTail;

    // Same 16 bits seen as R-type tail or I-type immediate
    typedef union packed {
        rTail        r;
        logic [15:0] imm;
    } lowHalf;

    typedef struct packed {
        regIndex rs;
        regIndex rt;
        lowHalf  low;
    } regFields;

    // Bits 25 to 0, register form or J-type target
    typedef union packed {
        regFields    regs;
        logic [25:0] target;
    } instrBody;

    // Exactly one instruction word
    typedef struct packed {
        opcode    op;
        instrBody body;
    } instrFields;

endpackage

/* verilog/mipsSettings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data and address width of the integer core
`define MIPS_XLEN 32

// Integer register file depth
`define MIPS_NUM_REGS 32

// Data memory word address width
`define MIPS_MEM_AW 7

// First fetch address after reset
`define MIPS_RESET_PC 0

// Link register written by jal
`define MIPS_RA_REG 31

`endif
